/* run_sim.sh */
#!/bin/sh
# Build the alu_imm testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module alu_imm_tb -o alu_imm_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/alu_imm_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Testbench passed$"; then
    exit 0
fi
exit 1

/* source/alu_imm_dq.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_imm_dq #(
    parameter int DQ_ENTRIES = 8
) (
    input  logic CLK,
    input  logic nRST,

    // Enqueue from rename, valid slots packed from slot 0
    input  logic [core_types_pkg::LANES-1:0] enQ_valid_array,
    input  logic [core_types_pkg::LANES-1:0][3:0] enQ_op_array,
    input  logic [core_types_pkg::LANES-1:0][31:0] enQ_imm_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] enQ_A_PR_array,
    input  logic [core_types_pkg::LANES-1:0] enQ_A_unneeded_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] enQ_dest_PR_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_ROB_ENTRIES-1:0]
                 enQ_ROB_index_array,
    output logic [core_types_pkg::LANES-1:0] enQ_ready_array,

    // Dequeue toward the execute lanes
    alu_imm_op_if.producer deq
);

    localparam int LOG_DQ_ENTRIES = $clog2(DQ_ENTRIES);

    typedef logic [LOG_DQ_ENTRIES-1:0] dq_idx_t;
    typedef logic [$clog2(core_types_pkg::LANES):0] delta_t;

    // --------------------------------------------------
    // Entry storage
    // --------------------------------------------------
    logic [DQ_ENTRIES-1:0] valid_by_entry;
    core_types_pkg::alu_imm_op_t [DQ_ENTRIES-1:0] op_by_entry;
    logic [DQ_ENTRIES-1:0][31:0] imm_by_entry;
    logic [DQ_ENTRIES-1:0] a_unneeded_by_entry;
    logic [DQ_ENTRIES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] a_pr_by_entry;
    logic [DQ_ENTRIES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] dest_pr_by_entry;
    logic [DQ_ENTRIES-1:0][core_types_pkg::LOG_ROB_ENTRIES-1:0] rob_index_by_entry;

    // One pointer per slot, all stepping together
    dq_idx_t [core_types_pkg::LANES-1:0] enq_idx_array;
    dq_idx_t [core_types_pkg::LANES-1:0] deq_idx_array;

    logic [core_types_pkg::LANES-1:0] enq_accepted;
    logic [core_types_pkg::LANES-1:0] deq_accepted;
    delta_t enq_delta;
    delta_t deq_delta;
    logic [DQ_ENTRIES-1:0] wr_mask;
    logic [DQ_ENTRIES-1:0] clr_mask;

    always_comb begin
        for (int i = 0; i < core_types_pkg::LANES; i++) begin
            enQ_ready_array[i] = ~valid_by_entry[enq_idx_array[i]];
            deq.valid[i] = valid_by_entry[deq_idx_array[i]];
            deq.op[i] = op_by_entry[deq_idx_array[i]];
            deq.imm[i] = imm_by_entry[deq_idx_array[i]];
            deq.A_PR[i] = a_pr_by_entry[deq_idx_array[i]];
            deq.A_unneeded[i] = a_unneeded_by_entry[deq_idx_array[i]];
            deq.dest_PR[i] = dest_pr_by_entry[deq_idx_array[i]];
            deq.ROB_index[i] = rob_index_by_entry[deq_idx_array[i]];
        end
        enq_accepted = enQ_valid_array & enQ_ready_array;
        deq_accepted = deq.valid & deq.ready;

        // Step is the highest accepted slot plus one
        enq_delta = '0;
        deq_delta = '0;
        wr_mask = '0;
        clr_mask = '0;
        for (int i = 0; i < core_types_pkg::LANES; i++) begin
            if (enq_accepted[i]) begin
                enq_delta = delta_t'(i + 1);
                wr_mask[enq_idx_array[i]] = 1'b1;
            end
            if (deq_accepted[i]) begin
                deq_delta = delta_t'(i + 1);
                clr_mask[deq_idx_array[i]] = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Sequential state
    // --------------------------------------------------
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_by_entry <= '0;
            for (int i = 0; i < core_types_pkg::LANES; i++) begin
                enq_idx_array[i] <= dq_idx_t'(i);
                deq_idx_array[i] <= dq_idx_t'(i);
            end
        end else begin
            valid_by_entry <= (valid_by_entry & ~clr_mask) | wr_mask;
            for (int i = 0; i < core_types_pkg::LANES; i++) begin
                enq_idx_array[i] <= enq_idx_array[i] + dq_idx_t'(enq_delta);
                deq_idx_array[i] <= deq_idx_array[i] + dq_idx_t'(deq_delta);
            end
        end
    end

    // Payload loads only on an accepted enqueue
    always_ff @(posedge CLK) begin
        for (int i = 0; i < core_types_pkg::LANES; i++) begin
            if (enq_accepted[i]) begin
                op_by_entry[enq_idx_array[i]] <= core_types_pkg::alu_imm_op_t'(enQ_op_array[i]);
                imm_by_entry[enq_idx_array[i]] <= enQ_imm_array[i];
                a_pr_by_entry[enq_idx_array[i]] <= enQ_A_PR_array[i];
                a_unneeded_by_entry[enq_idx_array[i]] <= enQ_A_unneeded_array[i];
                dest_pr_by_entry[enq_idx_array[i]] <= enQ_dest_PR_array[i];
                rob_index_by_entry[enq_idx_array[i]] <= enQ_ROB_index_array[i];
            end
        end
    end

    // Rename must pack valid slots from slot 0
    a_enq_contiguous: assert property (@(posedge CLK) disable iff (!nRST)
        (enQ_valid_array & (enQ_valid_array + 1'b1)) == '0);

    // Accepted slots stay a prefix, so no pointer step jumps over an op
    a_no_lost_op: assert property (@(posedge CLK) disable iff (!nRST)
        (enq_accepted & (enq_accepted + 1'b1)) == '0
            && (deq_accepted & (deq_accepted + 1'b1)) == '0);

    // Execute side readies form a prefix from slot 0
    a_deq_ready_prefix: assert property (@(posedge CLK) disable iff (!nRST)
        (deq.ready & (deq.ready + 1'b1)) == '0);

endmodule

`default_nettype wire

/* source/alu_imm_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_imm_exec (
    input  logic CLK,
    input  logic nRST,
    input  logic exec_stall,

    // Ops offered by the dispatch queue
    alu_imm_op_if.consumer deq,

    // Operand A read ports
    output logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] rd_PR_array,
    input  logic [core_types_pkg::LANES-1:0][31:0] rd_value_array,

    // Registered writebacks
    output logic [core_types_pkg::LANES-1:0] wb_valid_array,
    output logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] wb_dest_PR_array,
    output logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_ROB_ENTRIES-1:0]
                 wb_ROB_index_array,
    output logic [core_types_pkg::LANES-1:0][31:0] wb_value_array
);

    logic [core_types_pkg::LANES-1:0] take;
    logic [core_types_pkg::LANES-1:0][31:0] operand_a;
    logic [core_types_pkg::LANES-1:0][31:0] result;
    logic dest_clash;

    function automatic logic [31:0] alu_eval(
        input core_types_pkg::alu_imm_op_t op,
        input logic [31:0] a,
        input logic [31:0] imm
    );
        logic [31:0] res;
        case (op)
            core_types_pkg::ADDI:  res = a + imm;
            core_types_pkg::SLTI:  res = {31'b0, $signed(a) < $signed(imm)};
            core_types_pkg::SLTIU: res = {31'b0, a < imm};
            core_types_pkg::XORI:  res = a ^ imm;
            core_types_pkg::ORI:   res = a | imm;
            core_types_pkg::ANDI:  res = a & imm;
            core_types_pkg::SLLI:  res = a << imm[4:0];
            core_types_pkg::SRLI:  res = a >> imm[4:0];
            core_types_pkg::SRAI:  res = $signed(a) >>> imm[4:0];
            core_types_pkg::LUI:   res = imm;
            default:               res = '0;
        endcase
        return res;
    endfunction

    // --------------------------------------------------
    // Operand fetch and evaluate
    // --------------------------------------------------
    always_comb begin
        deq.ready = {core_types_pkg::LANES{~exec_stall}};
        take = deq.valid & deq.ready;
        for (int i = 0; i < core_types_pkg::LANES; i++) begin
            rd_PR_array[i] = deq.A_PR[i];
            operand_a[i] = deq.A_unneeded[i] ? 32'b0 : rd_value_array[i];
            result[i] = alu_eval(deq.op[i], operand_a[i], deq.imm[i]);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb_valid_array <= '0;
        end else begin
            wb_valid_array <= take;
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < core_types_pkg::LANES; i++) begin
            if (take[i]) begin
                wb_dest_PR_array[i] <= deq.dest_PR[i];
                wb_ROB_index_array[i] <= deq.ROB_index[i];
                wb_value_array[i] <= result[i];
            end
        end
    end

    // Two lanes aiming at one register in the same cycle
    always_comb begin
        dest_clash = 1'b0;
        for (int i = 0; i < core_types_pkg::LANES; i++) begin
            for (int j = i + 1; j < core_types_pkg::LANES; j++) begin
                if (wb_valid_array[i] && wb_valid_array[j]
                        && wb_dest_PR_array[i] == wb_dest_PR_array[j]) begin
                    dest_clash = 1'b1;
                end
            end
        end
    end

    a_unique_dest: assert property (@(posedge CLK) disable iff (!nRST) !dest_clash);

endmodule

`default_nettype wire

/* source/alu_imm_op_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface alu_imm_op_if;

    // Per lane handshake
    logic [core_types_pkg::LANES-1:0] valid;
    logic [core_types_pkg::LANES-1:0] ready;

    // Per lane op fields
    core_types_pkg::alu_imm_op_t [core_types_pkg::LANES-1:0] op;
    logic [core_types_pkg::LANES-1:0][31:0] imm;
    logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] A_PR;
    logic [core_types_pkg::LANES-1:0] A_unneeded;
    logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] dest_PR;
    logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_ROB_ENTRIES-1:0] ROB_index;

    modport producer (
        output valid, op, imm, A_PR, A_unneeded, dest_PR, ROB_index,
        input  ready
    );

    modport consumer (
        input  valid, op, imm, A_PR, A_unneeded, dest_PR, ROB_index,
        output ready
    );

endinterface

`default_nettype wire

/* source/alu_imm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_imm_top #(
    parameter int DQ_ENTRIES = 8
) (
    input  logic CLK,
    input  logic nRST,

    // Enqueue from rename
    input  logic [core_types_pkg::LANES-1:0] enQ_valid_array,
    input  logic [core_types_pkg::LANES-1:0][3:0] enQ_op_array,
    input  logic [core_types_pkg::LANES-1:0][31:0] enQ_imm_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] enQ_A_PR_array,
    input  logic [core_types_pkg::LANES-1:0] enQ_A_unneeded_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] enQ_dest_PR_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_ROB_ENTRIES-1:0]
                 enQ_ROB_index_array,
    output logic [core_types_pkg::LANES-1:0] enQ_ready_array,

    input  logic exec_stall,

    // Register file fill
    input  logic preload_en,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0] preload_PR,
    input  logic [31:0] preload_value,

    // Writeback
    output logic [core_types_pkg::LANES-1:0] wb_valid_array,
    output logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] wb_dest_PR_array,
    output logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_ROB_ENTRIES-1:0]
                 wb_ROB_index_array,
    output logic [core_types_pkg::LANES-1:0][31:0] wb_value_array
);

    alu_imm_op_if deq_if ();

    logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] rd_PR_array;
    logic [core_types_pkg::LANES-1:0][31:0] rd_value_array;

    alu_imm_dq #(
        .DQ_ENTRIES(DQ_ENTRIES)
    ) alu_imm_dq_i (
        .CLK(CLK),
        .nRST(nRST),
        .enQ_valid_array(enQ_valid_array),
        .enQ_op_array(enQ_op_array),
        .enQ_imm_array(enQ_imm_array),
        .enQ_A_PR_array(enQ_A_PR_array),
        .enQ_A_unneeded_array(enQ_A_unneeded_array),
        .enQ_dest_PR_array(enQ_dest_PR_array),
        .enQ_ROB_index_array(enQ_ROB_index_array),
        .enQ_ready_array(enQ_ready_array),
        .deq(deq_if.producer)
    );

    alu_imm_exec alu_imm_exec_i (
        .CLK(CLK),
        .nRST(nRST),
        .exec_stall(exec_stall),
        .deq(deq_if.consumer),
        .rd_PR_array(rd_PR_array),
        .rd_value_array(rd_value_array),
        .wb_valid_array(wb_valid_array),
        .wb_dest_PR_array(wb_dest_PR_array),
        .wb_ROB_index_array(wb_ROB_index_array),
        .wb_value_array(wb_value_array)
    );

    // Writebacks double as the register file write ports
    phys_reg_file phys_reg_file_i (
        .CLK(CLK),
        .nRST(nRST),
        .rd_PR_array(rd_PR_array),
        .rd_value_array(rd_value_array),
        .wr_en_array(wb_valid_array),
        .wr_PR_array(wb_dest_PR_array),
        .wr_value_array(wb_value_array),
        .preload_en(preload_en),
        .preload_PR(preload_PR),
        .preload_value(preload_value)
    );

endmodule

`default_nettype wire

/* source/core_types_pkg.sv */
`default_nettype none

package core_types_pkg;

    // --------------------------------------------------
    // Physical register file and ROB sizing
    // --------------------------------------------------
    localparam int LOG_PR_COUNT = 6;
    localparam int PR_COUNT = 2 ** LOG_PR_COUNT;
    localparam int LOG_ROB_ENTRIES = 6;

    // Ops moved per cycle on enqueue, dequeue and execute
    localparam int LANES = 4;

    // --------------------------------------------------
    // Register-immediate ALU operations
    // --------------------------------------------------
    // Low three bits follow the RISC-V funct3 where one exists
    typedef enum logic [3:0] {
        ADDI  = 4'b0000,
        SLLI  = 4'b0001,
        SLTI  = 4'b0010,
        SLTIU = 4'b0011,
        XORI  = 4'b0100,
        SRLI  = 4'b0101,
        ORI   = 4'b0110,
        ANDI  = 4'b0111,
        SRAI  = 4'b1101,
        LUI   = 4'b1111
    } alu_imm_op_t;

endpackage

`default_nettype wire

/* source/phys_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module phys_reg_file (
    input  logic CLK,
    input  logic nRST,

    // Combinational read ports
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] rd_PR_array,
    output logic [core_types_pkg::LANES-1:0][31:0] rd_value_array,

    // Writeback ports
    input  logic [core_types_pkg::LANES-1:0] wr_en_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] wr_PR_array,
    input  logic [core_types_pkg::LANES-1:0][31:0] wr_value_array,

    // Fill port
    input  logic preload_en,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0] preload_PR,
    input  logic [31:0] preload_value
);

    logic [core_types_pkg::PR_COUNT-1:0][31:0] regs;

    always_comb begin
        for (int i = 0; i < core_types_pkg::LANES; i++) begin
            rd_value_array[i] = regs[rd_PR_array[i]];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '0;
        end else begin
            if (preload_en) begin
                regs[preload_PR] <= preload_value;
            end
            for (int i = 0; i < core_types_pkg::LANES; i++) begin
                if (wr_en_array[i]) begin
                    regs[wr_PR_array[i]] <= wr_value_array[i];
                end
            end
        end
    end

    // Fill traffic must stay off registers being written back
    for (genvar g = 0; g < core_types_pkg::LANES; g++) begin : g_preload_chk
        a_preload_vs_wb: assert property (@(posedge CLK) disable iff (!nRST)
            !(preload_en && wr_en_array[g] && wr_PR_array[g] == preload_PR));
    end

endmodule

`default_nettype wire

/* sources.f */
source/core_types_pkg.sv
source/alu_imm_op_if.sv
source/alu_imm_dq.sv
source/alu_imm_exec.sv
source/phys_reg_file.sv
source/alu_imm_top.sv
tests/alu_imm_checker.sv
tests/alu_imm_tb.sv

/* tests/alu_imm_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_imm_checker #(
    parameter int DQ_ENTRIES = 8
) (
    input  logic CLK,
    input  logic nRST,
    input  logic [core_types_pkg::LANES-1:0] enQ_valid_array,
    input  logic [core_types_pkg::LANES-1:0][3:0] enQ_op_array,
    input  logic [core_types_pkg::LANES-1:0][31:0] enQ_imm_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] enQ_A_PR_array,
    input  logic [core_types_pkg::LANES-1:0] enQ_A_unneeded_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] enQ_dest_PR_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_ROB_ENTRIES-1:0]
                 enQ_ROB_index_array,
    input  logic [core_types_pkg::LANES-1:0] enQ_ready_array,
    input  logic exec_stall,
    input  logic preload_en,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0] preload_PR,
    input  logic [31:0] preload_value,
    input  logic [core_types_pkg::LANES-1:0] wb_valid_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_PR_COUNT-1:0] wb_dest_PR_array,
    input  logic [core_types_pkg::LANES-1:0][core_types_pkg::LOG_ROB_ENTRIES-1:0]
                 wb_ROB_index_array,
    input  logic [core_types_pkg::LANES-1:0][31:0] wb_value_array,
    output int error_count,
    output int checked_count,
    output int outstanding
);

    localparam int LANES = core_types_pkg::LANES;

    typedef struct {
        logic [3:0] op;
        logic [31:0] imm;
        logic [core_types_pkg::LOG_PR_COUNT-1:0] a_pr;
        logic a_unneeded;
        logic [core_types_pkg::LOG_PR_COUNT-1:0] dest_pr;
        logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] rob;
        int enq_cycle;
        int stall_snap;
        logic was_empty;
    } model_op_t;

    model_op_t model_q[$];
    logic [31:0] model_regs [core_types_pkg::PR_COUNT];
    int errors = 0;
    int checked = 0;
    int pending_ops = 0;
    int cycle = 0;
    int stall_count = 0;
    int reset_edges = 0;
    logic stall_prev = 1'b0;

    assign error_count = errors;
    assign checked_count = checked;
    assign outstanding = pending_ops;

    // --------------------------------------------------
    // Expected result of one register-immediate op
    // --------------------------------------------------
    function automatic logic [31:0] expected_result(
        input logic [3:0] op,
        input logic [31:0] a,
        input logic [31:0] imm
    );
        logic [63:0] ext;
        logic [31:0] res;
        ext = {{32{a[31]}}, a};
        res = 32'h0;
        case (op)
            core_types_pkg::ADDI:  res = a + imm;
            core_types_pkg::SLTI: begin
                // Opposite signs, so the negative side is the smaller one
                if (a[31] != imm[31]) begin
                    res[0] = a[31];
                end else begin
                    res[0] = a < imm;
                end
            end
            core_types_pkg::SLTIU: res[0] = a < imm;
            core_types_pkg::XORI:  res = a ^ imm;
            core_types_pkg::ORI:   res = a | imm;
            core_types_pkg::ANDI:  res = a & imm;
            core_types_pkg::SLLI:  res = a << imm[4:0];
            core_types_pkg::SRLI:  res = a >> imm[4:0];
            core_types_pkg::SRAI: begin
                ext = ext >> imm[4:0];
                res = ext[31:0];
            end
            core_types_pkg::LUI:   res = imm;
            default:               res = 32'h0;
        endcase
        return res;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("FAILED at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
        errors++;
    endtask

    // Oldest outstanding op must match this lane
    task automatic check_writeback(input int lane);
        model_op_t rec;
        logic [31:0] a;
        if (model_q.size() == 0) begin
            $display("Writeback on lane %0d at %0t with no op outstanding", lane, $time);
            errors++;
        end else begin
            rec = model_q.pop_front();
            a = rec.a_unneeded ? 32'h0 : model_regs[rec.a_pr];
            checked++;
            if (wb_ROB_index_array[lane] !== rec.rob) begin
                report_mismatch($sformatf("wb_ROB_index_array[%0d]", lane), rec.rob,
                                wb_ROB_index_array[lane]);
            end
            if (wb_dest_PR_array[lane] !== rec.dest_pr) begin
                report_mismatch($sformatf("wb_dest_PR_array[%0d]", lane), rec.dest_pr,
                                wb_dest_PR_array[lane]);
            end
            if (wb_value_array[lane] !== expected_result(rec.op, a, rec.imm)) begin
                report_mismatch($sformatf("wb_value_array[%0d]", lane),
                                expected_result(rec.op, a, rec.imm), wb_value_array[lane]);
            end
            // Empty queue and no stall in between gives the fixed two cycles
            if (rec.was_empty && stall_count == rec.stall_snap
                    && cycle - rec.enq_cycle != 2) begin
                report_mismatch("writeback latency", 2, cycle - rec.enq_cycle);
            end
        end
    endtask

    // --------------------------------------------------
    // Sample everything on the rising edge
    // --------------------------------------------------
    always @(posedge CLK) begin
        model_op_t rec;
        int occ;
        logic [LANES-1:0] exp_ready;
        logic empty_now;
        if (!nRST) begin
            if (reset_edges > 0 && enQ_ready_array !== '1) begin
                report_mismatch("enQ_ready_array in reset", {LANES{1'b1}}, enQ_ready_array);
            end
            if (reset_edges > 0 && wb_valid_array !== '0) begin
                report_mismatch("wb_valid_array in reset", 32'h0, wb_valid_array);
            end
            for (int r = 0; r < core_types_pkg::PR_COUNT; r++) begin
                model_regs[r] = 32'h0;
            end
            reset_edges++;
        end else begin
            // Entries held by the queue before this edge
            occ = model_q.size() - $countones(wb_valid_array);
            for (int i = 0; i < LANES; i++) begin
                exp_ready[i] = (occ + i) < DQ_ENTRIES;
            end
            if (enQ_ready_array !== exp_ready) begin
                report_mismatch("enQ_ready_array", exp_ready, enQ_ready_array);
            end
            if (wb_valid_array != '0 && stall_prev) begin
                $display("Writeback at %0t right after a stalled cycle", $time);
                errors++;
            end
            for (int i = 0; i < LANES; i++) begin
                if (wb_valid_array[i]) begin
                    check_writeback(i);
                end
            end
            stall_count += int'(exec_stall);
            stall_prev = exec_stall;
            empty_now = model_q.size() == 0;
            for (int i = 0; i < LANES; i++) begin
                if (enQ_valid_array[i] && enQ_ready_array[i]) begin
                    rec.op = enQ_op_array[i];
                    rec.imm = enQ_imm_array[i];
                    rec.a_pr = enQ_A_PR_array[i];
                    rec.a_unneeded = enQ_A_unneeded_array[i];
                    rec.dest_pr = enQ_dest_PR_array[i];
                    rec.rob = enQ_ROB_index_array[i];
                    rec.enq_cycle = cycle;
                    rec.stall_snap = stall_count;
                    rec.was_empty = empty_now;
                    model_q.push_back(rec);
                end
            end
            if (preload_en) begin
                model_regs[preload_PR] = preload_value;
            end
            cycle++;
        end
        pending_ops = model_q.size();
    end

endmodule

`default_nettype wire

/* tests/alu_imm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_imm_tb;

    localparam int LANES = core_types_pkg::LANES;
    localparam int PRW = core_types_pkg::LOG_PR_COUNT;
    localparam int ROBW = core_types_pkg::LOG_ROB_ENTRIES;
    localparam int DQ_ENTRIES = 8;
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int BURST_OPS = 200;
    localparam int MIXED_OPS = 400;
    // Reset, idle, preload, single ops, stall fill, then at worst one op per cycle
    localparam int STIM_CYCLES = RESET_CYCLES + 4 + 33 + 11 * 8 + BURST_OPS + 30
                                 + 2 * MIXED_OPS;
    localparam int MARGIN_CYCLES = 200;

    typedef struct packed {
        logic [3:0] op;
        logic [31:0] imm;
        logic [PRW-1:0] a_pr;
        logic a_unneeded;
        logic [PRW-1:0] dest_pr;
        logic [ROBW-1:0] rob;
    } op_rec_t;

    logic CLK;
    logic nRST;
    logic [LANES-1:0] enQ_valid_array;
    logic [LANES-1:0][3:0] enQ_op_array;
    logic [LANES-1:0][31:0] enQ_imm_array;
    logic [LANES-1:0][PRW-1:0] enQ_A_PR_array;
    logic [LANES-1:0] enQ_A_unneeded_array;
    logic [LANES-1:0][PRW-1:0] enQ_dest_PR_array;
    logic [LANES-1:0][ROBW-1:0] enQ_ROB_index_array;
    logic [LANES-1:0] enQ_ready_array;
    logic exec_stall;
    logic preload_en;
    logic [PRW-1:0] preload_PR;
    logic [31:0] preload_value;
    logic [LANES-1:0] wb_valid_array;
    logic [LANES-1:0][PRW-1:0] wb_dest_PR_array;
    logic [LANES-1:0][ROBW-1:0] wb_ROB_index_array;
    logic [LANES-1:0][31:0] wb_value_array;
    int error_count;
    int checked_count;
    int outstanding;

    op_rec_t pending[$];
    logic [31:0] lcg_state;
    int rob_next;
    int test_num;
    int errors_before;
    int checked_before;

    alu_imm_top #(.DQ_ENTRIES(DQ_ENTRIES)) alu_imm_top_i (.*);

    alu_imm_checker #(.DQ_ENTRIES(DQ_ENTRIES)) alu_imm_checker_i (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (STIM_CYCLES + MARGIN_CYCLES));
        $display("Watchdog expired with %0d ops still outstanding", outstanding);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int random_below(input int n);
        logic [31:0] r;
        r = next_random();
        return int'(r[30:16]) % n;
    endfunction

    // Sources come from 0 to 31, destinations step through 32 to 63
    function automatic op_rec_t make_op(input logic [3:0] code, input logic unneeded);
        op_rec_t r;
        r.op = code;
        r.imm = next_random();
        if (random_below(4) == 0) begin
            r.imm = {{20{r.imm[11]}}, r.imm[11:0]};
        end
        r.a_pr = PRW'(random_below(32));
        r.a_unneeded = unneeded;
        r.dest_pr = PRW'(32 + rob_next % 32);
        r.rob = ROBW'(rob_next % 64);
        rob_next++;
        return r;
    endfunction

    task automatic add_random_ops(input int n);
        for (int k = 0; k < n; k++) begin
            pending.push_back(make_op(4'(random_below(16)), random_below(8) == 0));
        end
    endtask

    // One cycle of enqueue traffic from the head of pending
    task automatic offer_slots(input int burst, input logic stall);
        int n;
        int taken;
        @(negedge CLK);
        n = (burst < pending.size()) ? burst : pending.size();
        exec_stall = stall;
        enQ_valid_array = '0;
        for (int i = 0; i < n; i++) begin
            enQ_valid_array[i] = 1'b1;
            enQ_op_array[i] = pending[i].op;
            enQ_imm_array[i] = pending[i].imm;
            enQ_A_PR_array[i] = pending[i].a_pr;
            enQ_A_unneeded_array[i] = pending[i].a_unneeded;
            enQ_dest_PR_array[i] = pending[i].dest_pr;
            enQ_ROB_index_array[i] = pending[i].rob;
        end
        // Ready depends only on queue state, so it holds until the next edge
        taken = 0;
        for (int i = 0; i < n; i++) begin
            if (enQ_ready_array[i]) begin
                taken++;
            end
        end
        repeat (taken) void'(pending.pop_front());
    endtask

    task automatic drain();
        @(negedge CLK);
        enQ_valid_array = '0;
        exec_stall = 1'b0;
        while (outstanding != 0) begin
            @(negedge CLK);
        end
    endtask

    task automatic send_pending(input logic random_stall);
        logic stall;
        while (pending.size() > 0) begin
            stall = random_stall && random_below(4) == 0;
            offer_slots(1 + random_below(LANES), stall);
        end
        drain();
    endtask

    task automatic single_op(input logic [3:0] code, input logic unneeded);
        pending.push_back(make_op(code, unneeded));
        offer_slots(1, 1'b0);
        drain();
    endtask

    task automatic preload_sources();
        for (int r = 0; r < 32; r++) begin
            @(negedge CLK);
            preload_en = 1'b1;
            preload_PR = PRW'(r);
            preload_value = next_random();
        end
        @(negedge CLK);
        preload_en = 1'b0;
    endtask

    task automatic close_test(input string name);
        test_num++;
        $display("Test %0d %s: %0d writebacks checked, %0d errors", test_num, name,
                 checked_count - checked_before, error_count - errors_before);
        errors_before = error_count;
        checked_before = checked_count;
    endtask

    initial begin
        lcg_state = 32'd84028;
        rob_next = 0;
        test_num = 0;
        errors_before = 0;
        checked_before = 0;
        nRST = 1'b0;
        exec_stall = 1'b0;
        enQ_valid_array = '0;
        enQ_op_array = '0;
        enQ_imm_array = '0;
        enQ_A_PR_array = '0;
        enQ_A_unneeded_array = '0;
        enQ_dest_PR_array = '0;
        enQ_ROB_index_array = '0;
        preload_en = 1'b0;
        preload_PR = '0;
        preload_value = '0;
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;

        repeat (4) offer_slots(0, 1'b0);
        close_test("reset state");

        preload_sources();
        single_op(core_types_pkg::ADDI, 1'b0);
        single_op(core_types_pkg::SLTI, 1'b0);
        single_op(core_types_pkg::SLTIU, 1'b0);
        single_op(core_types_pkg::XORI, 1'b0);
        single_op(core_types_pkg::ORI, 1'b0);
        single_op(core_types_pkg::ANDI, 1'b0);
        single_op(core_types_pkg::SLLI, 1'b0);
        single_op(core_types_pkg::SRLI, 1'b0);
        single_op(core_types_pkg::SRAI, 1'b0);
        single_op(core_types_pkg::LUI, 1'b1);
        single_op(4'b1000, 1'b0);
        close_test("one op of each opcode");

        add_random_ops(BURST_OPS);
        send_pending(1'b0);
        close_test("random bursts");

        // Eight fill the queue, four more wait behind a full queue
        add_random_ops(12);
        repeat (7) offer_slots(LANES, 1'b1);
        send_pending(1'b0);
        close_test("stall fill and drain");

        add_random_ops(MIXED_OPS);
        send_pending(1'b1);
        close_test("random stalls with bursts");

        $display("Tests run: %0d, writebacks checked: %0d of %0d, errors: %0d",
                 test_num, checked_count, rob_next, error_count);
        if (error_count == 0 && checked_count == rob_next) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
